//--- mesh_router.f
rtl/noc_pkg.sv
rtl/router_input_unit.sv
rtl/lookahead_route.sv
rtl/output_arbiter.sv
rtl/output_port.sv
rtl/mesh_router.sv
verification/mesh_router_tb.sv

//--- rtl/lookahead_route.sv
// combinational; position at the mesh edge must not be routed off the mesh by the caller
`default_nettype none

module lookahead_route (
  input  noc_pkg::xy_t    position_i,
  input  noc_pkg::port_e  out_port_i,
  input  noc_pkg::xy_t    dest_i,
  output noc_pkg::route_t next_route_o
);

  noc_pkg::xy_t next_pos;

  // router that receives the flit through this output
  assign next_pos = noc_pkg::neighbor_xy(position_i, out_port_i);

  //////////////////////////////////////////////////////////////////////
  // route decision made one hop ahead
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (out_port_i == noc_pkg::port_local) begin
      // worm leaves the network here
      next_route_o = '0;
    end else begin
      next_route_o = noc_pkg::xy_route(next_pos, dest_i);
    end
  end

endmodule

`default_nettype wire

//--- rtl/mesh_router.sv
// five-port XY wormhole router; position_i must stay static and inside an 8x8 mesh
`default_nettype none

module mesh_router #(
  parameter int DataWidth = noc_pkg::data_w_dflt,
  parameter int FifoDepth = noc_pkg::fifo_depth_dflt
) (
  input  logic                 clk,
  input  logic                 rst,
  input  noc_pkg::xy_t         position_i,
  input  logic [DataWidth+1:0] data_n_i,
  input  logic [DataWidth+1:0] data_s_i,
  input  logic [DataWidth+1:0] data_w_i,
  input  logic [DataWidth+1:0] data_e_i,
  input  logic [DataWidth+1:0] data_l_i,
  input  logic [4:0]           void_i,
  output logic [4:0]           stop_o,
  output logic [DataWidth+1:0] data_n_o,
  output logic [DataWidth+1:0] data_s_o,
  output logic [DataWidth+1:0] data_w_o,
  output logic [DataWidth+1:0] data_e_o,
  output logic [DataWidth+1:0] data_l_o,
  output logic [4:0]           void_o,
  input  logic [4:0]           stop_i
);

  localparam int NumPorts = noc_pkg::num_ports;

  logic [NumPorts-1:0][DataWidth+1:0]  in_data;
  logic [NumPorts-1:0][DataWidth+1:0]  out_data;
  logic [NumPorts-1:0][DataWidth+1:0]  head_flit;
  logic [NumPorts-1:0]                 head_valid;
  logic [NumPorts-1:0]                 pop_any;
  noc_pkg::route_t [NumPorts-1:0]      req;
  // row o holds the one-hot input choice of output o
  logic [NumPorts-1:0][NumPorts-1:0]   pop_mat;

  assign in_data[noc_pkg::port_north] = data_n_i;
  assign in_data[noc_pkg::port_south] = data_s_i;
  assign in_data[noc_pkg::port_west]  = data_w_i;
  assign in_data[noc_pkg::port_east]  = data_e_i;
  assign in_data[noc_pkg::port_local] = data_l_i;

  assign data_n_o = out_data[noc_pkg::port_north];
  assign data_s_o = out_data[noc_pkg::port_south];
  assign data_w_o = out_data[noc_pkg::port_west];
  assign data_e_o = out_data[noc_pkg::port_east];
  assign data_l_o = out_data[noc_pkg::port_local];

  // an input is read when any output selects it
  always_comb begin
    pop_any = '0;
    for (int o = 0; o < NumPorts; o++) begin
      pop_any |= pop_mat[o];
    end
  end

  for (genvar g = 0; g < NumPorts; g++) begin : gen_port
    router_input_unit #(
      .DataWidth(DataWidth),
      .FifoDepth(FifoDepth)
    ) u_in (
      .clk         (clk),
      .rst         (rst),
      .data_i      (in_data[g]),
      .void_i      (void_i[g]),
      .pop_i       (pop_any[g]),
      .full_o      (stop_o[g]),
      .head_valid_o(head_valid[g]),
      .head_flit_o (head_flit[g]),
      .req_o       (req[g])
    );

    output_port #(
      .DataWidth(DataWidth)
    ) u_out (
      .clk         (clk),
      .rst         (rst),
      .position_i  (position_i),
      .out_port_i  (noc_pkg::port_e'(g)),
      .head_flit_i (head_flit),
      .head_valid_i(head_valid),
      .req_i       (req),
      .stop_i      (stop_i[g]),
      .pop_o       (pop_mat[g]),
      .data_o      (out_data[g]),
      .void_o      (void_o[g])
    );
  end

endmodule

`default_nettype wire

//--- rtl/noc_pkg.sv
// mesh of at most 8x8 routers, unicast only; DataWidth must be at least 17 to hold a head flit
`default_nettype none

package noc_pkg;

  //////////////////////////////////////////////////////////////////////
  // ports and coordinates
  //////////////////////////////////////////////////////////////////////

  localparam int num_ports = 5;

  // index of each router port, also the bit position in a route_t
  typedef enum logic [2:0] {
    port_north = 3'd0,
    port_south = 3'd1,
    port_west  = 3'd2,
    port_east  = 3'd3,
    port_local = 3'd4
  } port_e;

  localparam int coord_w = 3;

  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
  } xy_t;

  // one-hot output choice, zero means no request
  typedef logic [num_ports-1:0] route_t;

  //////////////////////////////////////////////////////////////////////
  // flit format
  //////////////////////////////////////////////////////////////////////

  // head flit: preamble | source | destination | reserved | route
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  localparam int fifo_depth_dflt = 4;
  localparam int data_w_dflt     = 32;

  //////////////////////////////////////////////////////////////////////
  // XY dimension-order helpers
  //////////////////////////////////////////////////////////////////////

  // x first, then y, then deliver locally
  function automatic route_t xy_route(xy_t cur, xy_t dest);
    route_t r;
    r = '0;
    if (dest.x > cur.x) begin
      r[port_east] = 1'b1;
    end else if (dest.x < cur.x) begin
      r[port_west] = 1'b1;
    end else if (dest.y > cur.y) begin
      r[port_south] = 1'b1;
    end else if (dest.y < cur.y) begin
      r[port_north] = 1'b1;
    end else begin
      r[port_local] = 1'b1;
    end
    return r;
  endfunction

  // position of the router behind a given output; local stays put
  function automatic xy_t neighbor_xy(xy_t cur, port_e port);
    xy_t nb;
    nb = cur;
    case (port)
      port_north: nb.y = cur.y - 1'b1;
      port_south: nb.y = cur.y + 1'b1;
      port_west:  nb.x = cur.x - 1'b1;
      port_east:  nb.x = cur.x + 1'b1;
      default:    nb = cur;
    endcase
    return nb;
  endfunction

endpackage

`default_nettype wire

//--- rtl/output_arbiter.sv
// round-robin over five inputs; reserve_i and tail_done_i must never be high together
`default_nettype none

module output_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [noc_pkg::num_ports-1:0]   req_i,
  input  logic                            reserve_i,
  input  logic                            tail_done_i,
  output noc_pkg::route_t                 grant_o,
  output logic                            grant_valid_o
);

  localparam int NumPorts = noc_pkg::num_ports;

  logic            lock_q;
  noc_pkg::route_t grant_q;
  noc_pkg::route_t rr_grant;
  logic [2:0]      ptr_q;
  logic [2:0]      win_idx;

  // first requester at or after the priority pointer
  always_comb begin : rr_pick
    int   idx;
    logic found;
    rr_grant = '0;
    win_idx  = ptr_q;
    found    = 1'b0;
    for (int k = 0; k < NumPorts; k++) begin
      idx = (int'(ptr_q) + k) % NumPorts;
      if (!found && req_i[idx]) begin
        found         = 1'b1;
        rr_grant[idx] = 1'b1;
        win_idx       = 3'(idx);
      end
    end
  end

  // locked grant wins for the rest of the worm
  assign grant_o       = lock_q ? grant_q : rr_grant;
  assign grant_valid_o = lock_q | (|rr_grant);

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
      ptr_q   <= '0;
    end else if (tail_done_i) begin
      lock_q  <= 1'b0;
      grant_q <= '0;
    end else if (reserve_i && !lock_q && (|rr_grant)) begin
      lock_q  <= 1'b1;
      grant_q <= rr_grant;
      // winner drops to lowest priority
      ptr_q   <= (win_idx == 3'(NumPorts - 1)) ? 3'd0 : win_idx + 3'd1;
    end
  end

  // the granted input keeps requesting until its tail has left
  a_locked_grant_requested: assert property (@(posedge clk) disable iff (rst)
    lock_q |-> |(grant_q & req_i))
    else $error("output arbiter: locked grant lost its request");

endmodule

`default_nettype wire

//--- rtl/output_port.sv
// registered output with stop/void handshake; stop_i high freezes data_o, void_o and the input
`default_nettype none

module output_port #(
  parameter int DataWidth = noc_pkg::data_w_dflt
) (
  input  logic                                            clk,
  input  logic                                            rst,
  input  noc_pkg::xy_t                                    position_i,
  input  noc_pkg::port_e                                  out_port_i,
  input  logic [noc_pkg::num_ports-1:0][DataWidth+1:0]    head_flit_i,
  input  logic [noc_pkg::num_ports-1:0]                   head_valid_i,
  input  noc_pkg::route_t [noc_pkg::num_ports-1:0]        req_i,
  input  logic                                            stop_i,
  output logic [noc_pkg::num_ports-1:0]                   pop_o,
  output logic [DataWidth+1:0]                            data_o,
  output logic                                            void_o
);

  localparam int NumPorts = noc_pkg::num_ports;
  localparam int XyW      = $bits(noc_pkg::xy_t);
  localparam int RouteW   = $bits(noc_pkg::route_t);

  typedef enum logic [1:0] {
    st_reserve = 2'd0,
    st_head    = 2'd1,
    st_payload = 2'd2
  } state_e;

  state_e               state_q;
  state_e               state_d;
  logic [NumPorts-1:0]  own_req;
  noc_pkg::route_t      grant;
  logic                 grant_valid;
  logic                 reserve;
  logic                 fwd;
  logic                 tail_done;
  logic                 sel_valid;
  logic [DataWidth+1:0] sel_flit;
  logic [DataWidth+1:0] out_flit;
  noc_pkg::preamble_t   sel_pre;
  noc_pkg::xy_t         sel_dest;
  noc_pkg::route_t      next_route;

  // each input's request bit for this output
  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      own_req[i] = req_i[i][out_port_i];
    end
  end

  output_arbiter u_arb (
    .clk          (clk),
    .rst          (rst),
    .req_i        (own_req),
    .reserve_i    (reserve),
    .tail_done_i  (tail_done),
    .grant_o      (grant),
    .grant_valid_o(grant_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // crossbar column and look-ahead field
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_flit  = '0;
    sel_valid = 1'b0;
    for (int i = 0; i < NumPorts; i++) begin
      if (grant[i]) begin
        sel_flit  = head_flit_i[i];
        sel_valid = head_valid_i[i];
      end
    end
  end

  assign sel_pre  = sel_flit[DataWidth+1:DataWidth];
  assign sel_dest = sel_flit[DataWidth-XyW-1:DataWidth-2*XyW];

  lookahead_route u_la (
    .position_i  (position_i),
    .out_port_i  (out_port_i),
    .dest_i      (sel_dest),
    .next_route_o(next_route)
  );

  // only the head of a worm gets the next hop's route
  assign out_flit = (state_q == st_head) ? {sel_flit[DataWidth+1:RouteW], next_route} : sel_flit;

  //////////////////////////////////////////////////////////////////////
  // flow control FSM
  //////////////////////////////////////////////////////////////////////

  assign reserve   = (state_q == st_reserve) && grant_valid && !stop_i;
  assign fwd       = (state_q != st_reserve) && sel_valid && !stop_i;
  assign tail_done = fwd && sel_pre.tail;
  assign pop_o     = fwd ? grant : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_reserve: begin
        if (reserve) begin
          state_d = st_head;
        end
      end
      st_head: begin
        if (fwd) begin
          // single-flit packet goes straight back to reserve
          state_d = sel_pre.tail ? st_reserve : st_payload;
        end
      end
      st_payload: begin
        if (tail_done) begin
          state_d = st_reserve;
        end
      end
      default: state_d = st_reserve;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_reserve;
    end else begin
      state_q <= state_d;
    end
  end

  // output register, held while downstream stops
  always_ff @(posedge clk) begin
    if (rst) begin
      void_o <= 1'b1;
    end else if (!stop_i) begin
      void_o <= ~fwd;
    end
  end

  always_ff @(posedge clk) begin
    if (fwd) begin
      data_o <= out_flit;
    end
  end

  // input queue ordering must place a head first in every worm
  a_head_state_carries_head: assert property (@(posedge clk) disable iff (rst)
    (state_q == st_head && fwd) |-> sel_pre.head)
    else $error("output port: worm started by a non-head flit");

endmodule

`default_nettype wire

//--- rtl/router_input_unit.sv
// sender must keep void_i high while full_o is high; at most one pop per cycle across outputs
`default_nettype none

module router_input_unit #(
  parameter int DataWidth = noc_pkg::data_w_dflt,
  parameter int FifoDepth = noc_pkg::fifo_depth_dflt
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [DataWidth+1:0] data_i,
  input  logic                 void_i,
  input  logic                 pop_i,
  output logic                 full_o,
  output logic                 head_valid_o,
  output logic [DataWidth+1:0] head_flit_o,
  output noc_pkg::route_t      req_o
);

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  logic [DataWidth+1:0] mem_q [FifoDepth];
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [PtrW:0]        count_q;
  logic                 push;
  logic                 pop;
  noc_pkg::preamble_t   head_pre;
  noc_pkg::route_t      held_req_q;

  // wrap for depths that are not a power of two
  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] p);
    return (p == PtrW'(FifoDepth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full_o       = (count_q == (PtrW+1)'(FifoDepth));
  assign head_valid_o = (count_q != '0);
  assign push         = ~void_i & ~full_o;
  assign pop          = pop_i & head_valid_o;
  assign head_flit_o  = mem_q[rd_ptr_q];
  assign head_pre     = head_flit_o[DataWidth+1:DataWidth];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // request of the worm in flight, kept until its tail leaves
  always_ff @(posedge clk) begin
    if (rst) begin
      held_req_q <= '0;
    end else if (pop && head_pre.tail) begin
      held_req_q <= '0;
    end else if (pop && head_pre.head) begin
      held_req_q <= head_flit_o[$bits(noc_pkg::route_t)-1:0];
    end
  end

  assign req_o = (head_valid_o && head_pre.head) ?
                 head_flit_o[$bits(noc_pkg::route_t)-1:0] : held_req_q;

  // upstream router honours stop_o
  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    !void_i |-> !full_o)
    else $error("input unit: flit offered while queue full");

  // output ports only read a queue that holds a flit
  a_pop_needs_head: assert property (@(posedge clk) disable iff (rst)
    pop_i |-> head_valid_o)
    else $error("input unit: pop of an empty queue");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the mesh router testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module mesh_router_tb -Mdir build -o sim_mesh_router \
  -f mesh_router.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./build/sim_mesh_router > build/sim.log 2>&1
status=$?
cat build/sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" build/sim.log; then
  exit 1
fi
if ! grep -q "=== PASS ===" build/sim.log; then
  echo "simulation log holds no result line"
  exit 1
fi
exit 0

//--- verification/mesh_router_tb.sv
// DUT sits at (3,3) with DataWidth 32 and FifoDepth 4; expected flits come from a local XY model
`default_nettype none

module mesh_router_tb;

  localparam int DW       = 32;
  localparam int FW       = DW + 2;
  localparam int Depth    = 4;
  localparam int NumPorts = 5;
  localparam int NumTests = 12;
  localparam int NoPort   = 7;

  // one table row, a second sender is optional
  typedef struct packed {
    logic [2:0]   src_a;
    noc_pkg::xy_t dest_a;
    logic [2:0]   len_a;
    logic [2:0]   src_b;
    noc_pkg::xy_t dest_b;
    logic [2:0]   len_b;
    logic [1:0]   stall;
  } test_t;

  logic          clk = 1'b0;
  logic          rst;
  noc_pkg::xy_t  pos;
  logic [FW-1:0] data_in [NumPorts];
  logic [FW-1:0] data_out [NumPorts];
  logic [4:0]    void_in;
  logic [4:0]    void_out;
  logic [4:0]    stop_in;
  logic [4:0]    stop_out;

  test_t         tests [NumTests];
  string         test_name [NumTests];
  // expected flits per output and input pair
  logic [FW-1:0] exp_q [NumPorts*NumPorts][$];
  int            cur_in [NumPorts];
  int            acc_cnt [NumPorts];
  int            full_at [NumPorts];
  int            errors;
  int            checks;
  int            failed;
  int            cycles = 0;
  int            limit = 0;
  int            stall_mode;
  int            hold_port;
  int            hold_until;
  logic [31:0]   data_state;

  always #50 clk = ~clk;

  mesh_router #(
    .DataWidth(DW),
    .FifoDepth(Depth)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .position_i(pos),
    .data_n_i  (data_in[0]),
    .data_s_i  (data_in[1]),
    .data_w_i  (data_in[2]),
    .data_e_i  (data_in[3]),
    .data_l_i  (data_in[4]),
    .void_i    (void_in),
    .stop_o    (stop_out),
    .data_n_o  (data_out[0]),
    .data_s_o  (data_out[1]),
    .data_w_o  (data_out[2]),
    .data_e_o  (data_out[3]),
    .data_l_o  (data_out[4]),
    .void_o    (void_out),
    .stop_i    (stop_in)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // x dimension first; bit order n, s, w, e, local
  function automatic noc_pkg::route_t ref_route(noc_pkg::xy_t cur, noc_pkg::xy_t dst);
    noc_pkg::route_t r;
    r = '0;
    if (dst.x != cur.x) begin
      r[(dst.x > cur.x) ? 3 : 2] = 1'b1;
    end else if (dst.y != cur.y) begin
      r[(dst.y > cur.y) ? 1 : 0] = 1'b1;
    end else begin
      r[4] = 1'b1;
    end
    return r;
  endfunction

  function automatic noc_pkg::xy_t ref_next(noc_pkg::xy_t cur, int port);
    noc_pkg::xy_t n;
    n = cur;
    case (port)
      0: n.y = cur.y - 3'd1;
      1: n.y = cur.y + 3'd1;
      2: n.x = cur.x - 3'd1;
      3: n.x = cur.x + 3'd1;
      default: n = cur;
    endcase
    return n;
  endfunction

  function automatic int port_of(noc_pkg::route_t r);
    int k;
    port_of = -1;
    for (k = 0; k < NumPorts; k++) begin
      if (r[k]) begin
        port_of = k;
      end
    end
  endfunction

  // each input stamps its own upstream position as the source
  function automatic noc_pkg::xy_t src_of(int port);
    return ref_next(pos, port);
  endfunction

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string port_name(int p);
    case (p)
      0: return "north";
      1: return "south";
      2: return "west";
      3: return "east";
      default: return "local";
    endcase
  endfunction

  function automatic test_t row(int sa, int xa, int ya, int la, int sb, int xb, int yb, int lb,
                                int st);
    test_t t;
    t.src_a  = 3'(sa);
    t.dest_a = '{x: 3'(xa), y: 3'(ya)};
    t.len_a  = 3'(la);
    t.src_b  = 3'(sb);
    t.dest_b = '{x: 3'(xb), y: 3'(yb)};
    t.len_b  = 3'(lb);
    t.stall  = 2'(st);
    return t;
  endfunction

  function automatic int pending();
    int k;
    pending = 0;
    for (k = 0; k < NumPorts * NumPorts; k++) begin
      pending += exp_q[k].size();
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_xy(string what, noc_pkg::xy_t got, noc_pkg::xy_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got (%0d,%0d) expected (%0d,%0d)", $time, what,
               got.x, got.y, exp.x, exp.y);
    end
  endtask

  task automatic compare_route(string what, noc_pkg::route_t got, noc_pkg::route_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %05b expected %05b", $time, what, got, exp);
    end
  endtask

  task automatic compare_flit(string what, logic [FW-1:0] got, logic [FW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_mask(string what, logic [4:0] got, logic [4:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %05b expected %05b", $time, what, got, exp);
    end
  endtask

  // match a delivered flit against the worm that holds this output
  task automatic take_output(int o, logic [FW-1:0] got);
    int            i;
    int            k;
    logic [FW-1:0] exp;
    noc_pkg::xy_t  got_src;
    got_src = got[DW-1 -: 6];
    i = cur_in[o];
    if (i < 0) begin
      for (k = 0; k < NumPorts; k++) begin
        if (src_of(k) == got_src && exp_q[o*NumPorts+k].size() != 0) begin
          i = k;
        end
      end
    end
    if (i < 0 || exp_q[o*NumPorts+i].size() == 0) begin
      errors++;
      $display("output %s delivered a flit at %0t that no sender was waiting for",
               port_name(o), $time);
      return;
    end
    exp = exp_q[o*NumPorts+i].pop_front();
    if (exp[FW-1]) begin
      compare_xy("head source", got[DW-1 -: 6], exp[DW-1 -: 6]);
      compare_xy("head destination", got[DW-7 -: 6], exp[DW-7 -: 6]);
      compare_route("head route field", got[4:0], exp[4:0]);
    end
    compare_flit($sformatf("flit on output %s", port_name(o)), got, exp);
    cur_in[o] = exp[FW-2] ? -1 : i;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // entered 5 after a rising edge; offers a flit only while stop_o is low
  task automatic send_worm(int port, noc_pkg::xy_t dst, int len);
    logic [FW-1:0]   flits [4];
    logic [FW-1:0]   exp;
    noc_pkg::route_t here;
    noc_pkg::route_t next;
    int              out;
    int              i;
    here = ref_route(pos, dst);
    out  = port_of(here);
    for (i = 0; i < len; i++) begin
      data_state = lcg_step(data_state);
      if (i == 0) begin
        flits[i] = {1'b1, len == 1, src_of(port), dst, data_state[19:5], here};
        next     = (out == 4) ? '0 : ref_route(ref_next(pos, out), dst);
        exp      = {flits[i][FW-1:5], next};
      end else begin
        flits[i] = {1'b0, i == len - 1, data_state};
        exp      = flits[i];
      end
      exp_q[out*NumPorts+port].push_back(exp);
    end
    i = 0;
    while (i < len) begin
      if (!stop_out[port]) begin
        data_in[port] = flits[i];
        void_in[port] = 1'b0;
        i++;
      end else begin
        void_in[port] = 1'b1;
      end
      @(posedge clk);
      #5;
    end
    void_in[port] = 1'b1;
  endtask

  // output stalls: random, or one output held for a window
  initial begin : stall_drive
    logic [31:0] s;
    int          p;
    s = 32'd33587;
    stop_in = '0;
    forever begin
      @(posedge clk);
      #5;
      for (p = 0; p < NumPorts; p++) begin
        s = lcg_step(s);
        if (stall_mode == 1) begin
          stop_in[p] = (s[17:16] == 2'b00);
        end else if (stall_mode == 2 && p == hold_port && cycles < hold_until) begin
          stop_in[p] = 1'b1;
        end else begin
          stop_in[p] = 1'b0;
        end
      end
    end
  end

  // outputs and stop_o are stable at the falling edge
  initial begin : out_monitor
    int p;
    forever begin
      @(negedge clk);
      if (!rst) begin
        for (p = 0; p < NumPorts; p++) begin
          if (stop_out[p] && full_at[p] < 0) begin
            full_at[p] = acc_cnt[p];
          end
          if (!void_in[p] && !stop_out[p]) begin
            acc_cnt[p]++;
          end
          if (!void_out[p] && !stop_in[p]) begin
            take_output(p, data_out[p]);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: the run went past its limit of %0d cycles", limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin : main
    test_t t;
    int    n;
    int    p;
    int    total;
    int    err_before;
    rst        = 1'b1;
    pos        = '{x: 3'd3, y: 3'd3};
    void_in    = '1;
    errors     = 0;
    checks     = 0;
    failed     = 0;
    stall_mode = 0;
    hold_port  = 0;
    hold_until = 0;
    data_state = 32'd33587;
    for (p = 0; p < NumPorts; p++) begin
      data_in[p] = '0;
      cur_in[p]  = -1;
      acc_cnt[p] = 0;
      full_at[p] = -1;
    end

    // src, dest x, dest y, length for each sender, then stall mode
    tests[0]  = row(4, 5, 3, 1, NoPort, 0, 0, 0, 0);
    tests[1]  = row(4, 0, 3, 1, NoPort, 0, 0, 0, 0);
    tests[2]  = row(4, 3, 6, 1, NoPort, 0, 0, 0, 0);
    tests[3]  = row(4, 3, 0, 1, NoPort, 0, 0, 0, 0);
    tests[4]  = row(4, 3, 3, 1, NoPort, 0, 0, 0, 0);
    tests[5]  = row(2, 6, 1, 4, NoPort, 0, 0, 0, 0);
    tests[6]  = row(0, 3, 7, 3, NoPort, 0, 0, 0, 0);
    tests[7]  = row(2, 5, 5, 4, 1, 7, 2, 4, 0);
    tests[8]  = row(4, 1, 1, 3, 3, 0, 6, 4, 0);
    tests[9]  = row(0, 3, 7, 4, 2, 3, 0, 4, 1);
    tests[10] = row(4, 6, 6, 4, 1, 2, 2, 2, 1);
    tests[11] = row(4, 7, 3, 4, NoPort, 0, 0, 0, 2);
    test_name = '{"local_east", "local_west", "local_south", "local_north", "local_local",
                  "west_worm", "north_worm", "contend_east", "contend_west", "stall_rand_a",
                  "stall_rand_b", "queue_full"};

    total = 0;
    for (n = 0; n < NumTests; n++) begin
      total += int'(tests[n].len_a);
      if (tests[n].src_b != NoPort) begin
        total += int'(tests[n].len_b);
      end
    end
    limit = 40 * total + 200;

    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;

    err_before = errors;
    @(negedge clk);
    compare_mask("void_o after reset", void_out, 5'h1f);
    compare_mask("stop_o after reset", stop_out, 5'h00);
    failed += (errors != err_before);
    $display("test  0 %-14s %s", "reset_state", (errors == err_before) ? "ok" : "FAILED");
    @(posedge clk);
    #5;

    for (n = 0; n < NumTests; n++) begin
      t          = tests[n];
      err_before = errors;
      for (p = 0; p < NumPorts; p++) begin
        acc_cnt[p] = 0;
        full_at[p] = -1;
      end
      hold_port  = port_of(ref_route(pos, t.dest_a));
      hold_until = cycles + 12;
      stall_mode = int'(t.stall);
      fork
        send_worm(int'(t.src_a), t.dest_a, int'(t.len_a));
        if (t.src_b != NoPort) send_worm(int'(t.src_b), t.dest_b, int'(t.len_b));
      join
      while (pending() != 0) begin
        @(posedge clk);
        #5;
      end
      stall_mode = 0;

      if (t.stall == 2'd2) begin
        checks++;
        if (full_at[t.src_a] < 0) begin
          errors++;
          $display("input %s never raised stop_o while its output was stopped",
                   port_name(int'(t.src_a)));
        end else if (full_at[t.src_a] > Depth + 2) begin
          errors++;
          $display("[ERROR] %0t: stop_o rose after %0d accepted flits, limit %0d", $time,
                   full_at[t.src_a], Depth + 2);
        end
      end

      failed += (errors != err_before);
      $display("test %2d %-14s %s", n + 1, test_name[n], (errors == err_before) ? "ok" : "FAILED");
      repeat (2) begin
        @(posedge clk);
        #5;
      end
    end

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", NumTests + 1, failed,
             checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
